//--- rtl/uart_cfg_pkg.sv
/*
 * Clock, baud, framing and FIFO constants of the UART echo unit.
 * Imported by the RTL and by the testbench serial driver.
 */
package uart_cfg_pkg;

	// system clock and line rate
	localparam int CLK_FREQ_HZ  = 10_000_000;  // 100 ns period
	localparam int BAUD_RATE    = 625_000;

	// oversampling, one bit is this many clocks
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;  // 16
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);     // clock counter width

	// framing
	localparam int DATA_BITS    = 8;
	localparam int BIT_W        = $clog2(DATA_BITS);  // bit counter width
	localparam int TX_STOP_BITS = 2;  // receiver checks only the first stop bit

	/*
	 * echo queue between receiver and transmitter,
	 * depth must stay a power of two for pointer wrap
	 */
	localparam int FIFO_DEPTH   = 4;
	localparam int FIFO_AW      = $clog2(FIFO_DEPTH);

endpackage

//--- rtl/uart_types_pkg.sv
/*
 * Packed words shared by the echo RTL and its testbench:
 * the received byte with its framing flag, and the error status.
 */
package uart_types_pkg;

	// one received frame as reported by the receiver
	typedef struct packed {
		logic [7:0] data;       // payload, bit 0 arrived first
		logic       frame_err;  // first stop bit was sampled low
	} uart_byte_t;

	// top-level status, both counters saturate at 255
	typedef struct packed {
		logic [7:0] frame_err_cnt;
		logic [7:0] overrun_cnt;
	} err_stat_t;

endpackage

//--- rtl/uart_rx.sv
/*
 * UART receiver, 8N1 with CLKS_PER_BIT oversampling.
 * Rejects start glitches at mid-bit and flags a low stop bit.
 * rx_valid pulses for one cycle with rx_byte, there is no back-pressure.
 */
`timescale 1ns/1ps

module uart_rx
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output uart_byte_t rx_byte,
	output logic       rx_valid
);

	enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_DONE
	} state;

	logic                 rx_meta;   // first sync stage
	logic                 rx_sync;   // second sync stage
	logic                 rx_prev;   // for edge detect
	logic                 start_edge;
	logic [CNT_W-1:0]     clk_cnt;
	logic [BIT_W-1:0]     bit_cnt;
	logic [DATA_BITS-1:0] shift_reg;
	logic                 mid_bit;
	logic                 bit_end;

	assign start_edge = rx_prev & ~rx_sync;
	assign mid_bit    = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2));
	assign bit_end    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign rx_valid   = (state == RX_DONE);

	// line is idle high, so sync flops come out of reset at 1
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= RX_IDLE;
		end else begin
			case (state)
				RX_IDLE:
					if (start_edge)
						state <= RX_START;
				RX_START:
					if (mid_bit && rx_sync)
						state <= RX_IDLE;  // glitch, line back high
					else if (bit_end)
						state <= RX_DATA;
				RX_DATA:
					if (bit_end && bit_cnt == BIT_W'(DATA_BITS - 1))
						state <= RX_STOP;
				RX_STOP:
					if (mid_bit)
						state <= RX_DONE;
				RX_DONE:
					state <= RX_IDLE;
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// clocks within the current bit
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			clk_cnt <= '0;
		else if (state == RX_IDLE || state == RX_DONE)
			clk_cnt <= '0;
		else if (bit_end)
			clk_cnt <= '0;
		else
			clk_cnt <= clk_cnt + 1'b1;
	end

	// data bit index
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			bit_cnt <= '0;
		else if (state != RX_DATA)
			bit_cnt <= '0;
		else if (bit_end)
			bit_cnt <= bit_cnt + 1'b1;  // wraps to 0 after the last bit
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && mid_bit)
			shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
	end

	always_ff @(posedge sys_clk) begin
		if (state == RX_STOP && mid_bit) begin
			rx_byte.data      <= shift_reg;
			rx_byte.frame_err <= ~rx_sync;  // stop bit must be high
		end
	end

	// a frame takes many bit times, so two reports can never be adjacent
	a_valid_single : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid
	) else $error("uart_rx: rx_valid high on two consecutive cycles");

endmodule

//--- rtl/uart_tx.sv
/*
 * UART transmitter with a valid/ready byte input.
 * Sends start bit, DATA_BITS data bits lsb first, then TX_STOP_BITS stop bits.
 * A byte is taken only in idle, the start bit goes out on the next cycle.
 */
`timescale 1ns/1ps

module uart_tx
	import uart_cfg_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] in_data,
	input  logic       in_valid,
	output logic       in_ready,
	output logic       tx
);

	enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} state;

	logic [CNT_W-1:0]     clk_cnt;
	logic [BIT_W-1:0]     bit_cnt;   // data index, then stop index
	logic [DATA_BITS-1:0] shift_reg;
	logic                 bit_end;
	logic                 accept;

	assign in_ready = (state == TX_IDLE);
	assign accept   = in_valid & in_ready;
	assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	// tx is registered and changes together with the state
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= TX_IDLE;
			bit_cnt <= '0;
			tx      <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					bit_cnt <= '0;
					if (accept) begin
						state <= TX_START;
						tx    <= 1'b0;
					end
				end
				TX_START:
					if (bit_end) begin
						state <= TX_DATA;
						tx    <= shift_reg[0];
					end
				TX_DATA:
					if (bit_end) begin
						if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
							state   <= TX_STOP;
							bit_cnt <= '0;
							tx      <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							tx      <= shift_reg[1];  // next bit, before this shift
						end
					end
				TX_STOP:
					if (bit_end) begin
						if (bit_cnt == BIT_W'(TX_STOP_BITS - 1))
							state <= TX_IDLE;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			clk_cnt <= '0;
		else if (state == TX_IDLE || bit_end)
			clk_cnt <= '0;
		else
			clk_cnt <= clk_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			shift_reg <= in_data;
		else if (state == TX_DATA && bit_end)
			shift_reg <= shift_reg >> 1;
	end

	// line must rest high whenever a new byte may be taken
	a_idle_high : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		in_ready |-> tx
	) else $error("uart_tx: tx low while in_ready is high");

endmodule

//--- rtl/byte_fifo.sv
/*
 * Byte FIFO of FIFO_DEPTH entries between receiver and transmitter.
 * Write side has no ready: a write into a full FIFO is dropped and counted.
 * Read side is a valid/ready stream, rd_data is the head entry.
 */
`timescale 1ns/1ps

module byte_fifo
	import uart_cfg_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] wr_data,
	input  logic       wr_en,
	output logic [7:0] rd_data,
	output logic       rd_valid,
	input  logic       rd_ready,
	output logic [7:0] overrun_cnt
);

	logic [7:0]         mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;  // occupancy, needs one extra bit for full
	logic               full;
	logic               do_wr;
	logic               do_rd;

	assign full     = (count == FIFO_DEPTH[FIFO_AW:0]);
	assign do_wr    = wr_en & ~full;  // full drops even with a read pending
	assign do_rd    = rd_valid & rd_ready;
	assign rd_valid = (count != '0);
	assign rd_data  = mem[rd_ptr];

	always_ff @(posedge sys_clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// dropped writes, sticks at 255
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			overrun_cnt <= '0;
		else if (wr_en && full && overrun_cnt != 8'hff)
			overrun_cnt <= overrun_cnt + 1'b1;
	end

	a_no_overfill : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		count <= FIFO_DEPTH[FIFO_AW:0]
	) else $error("byte_fifo: occupancy above depth");

	// head entry held until the transmitter takes it
	a_head_stable : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		rd_valid && !rd_ready |=> rd_valid && $stable(rd_data)
	) else $error("byte_fifo: rd_data changed while stalled");

endmodule

//--- rtl/uart_echo_top.sv
/*
 * UART echo unit: receiver, byte FIFO and transmitter in a chain.
 * Good frames are queued and sent back on tx, bad frames are counted.
 */
`timescale 1ns/1ps

module uart_echo_top
	import uart_types_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  logic      rx,
	output logic      tx,
	output err_stat_t err_stat
);

	uart_byte_t rx_byte;
	logic       rx_valid;
	logic       fifo_wr;
	logic [7:0] fifo_data;
	logic       fifo_valid;
	logic       tx_ready;
	logic [7:0] frame_err_cnt;
	logic [7:0] overrun_cnt;

	uart_rx u_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (rx),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

	assign fifo_wr = rx_valid & ~rx_byte.frame_err;  // bad frames never queued

	byte_fifo u_fifo (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.wr_data     (rx_byte.data),
		.wr_en       (fifo_wr),
		.rd_data     (fifo_data),
		.rd_valid    (fifo_valid),
		.rd_ready    (tx_ready),
		.overrun_cnt (overrun_cnt)
	);

	uart_tx u_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.in_data   (fifo_data),
		.in_valid  (fifo_valid),
		.in_ready  (tx_ready),
		.tx        (tx)
	);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			frame_err_cnt <= '0;
		else if (rx_valid && rx_byte.frame_err && frame_err_cnt != 8'hff)
			frame_err_cnt <= frame_err_cnt + 1'b1;  // saturates
	end

	assign err_stat.frame_err_cnt = frame_err_cnt;
	assign err_stat.overrun_cnt   = overrun_cnt;

endmodule

//--- test/tb_clock_gen.sv
/*
 * Clock and reset source for the echo testbench.
 * sys_clk follows CLK_FREQ_HZ, reset is held low for the first RST_CYCLES cycles.
 */
`timescale 1ns/1ps

module tb_clock_gen
	import uart_cfg_pkg::*;
(
	output logic sys_clk,
	output logic sys_rst_n
);

	localparam int HALF_NS    = 1_000_000_000 / CLK_FREQ_HZ / 2;  // 50 ns
	localparam int RST_CYCLES = 5;

	initial begin
		sys_clk = 1'b0;
		forever #(HALF_NS) sys_clk = ~sys_clk;
	end

	// release just after an edge, like the rest of the stimulus
	initial begin
		sys_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge sys_clk);
		#1 sys_rst_n = 1'b1;
	end

endmodule

//--- test/tb_uart_echo.sv
/*
 * Testbench of the UART echo unit. Drives serial frames on rx, decodes tx,
 * and checks the echo stream and err_stat against a reference model.
 */
`timescale 1ns/1ps

module tb_uart_echo
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
();

	localparam int GAP_CYC       = 200;  // longer than one echo frame
	localparam int GLITCH_CYC    = 3;    // well under half a bit
	localparam int QUIET_CYC     = 400;
	localparam int RX_FRAME_CYC  = (DATA_BITS + 2) * CLKS_PER_BIT;
	localparam int TX_SLOT_CYC   = (DATA_BITS + 1 + TX_STOP_BITS) * CLKS_PER_BIT + 1;
	localparam int RANDOM_FRAMES = 20;
	localparam int BURST_FRAMES  = 64;
	localparam int TOTAL_FRAMES  = RANDOM_FRAMES + 7 + 1 + 4 + BURST_FRAMES;
	localparam int WATCHDOG_NS   = (TOTAL_FRAMES + 10) * (RX_FRAME_CYC + GAP_CYC) * 100;
	localparam int KIND_GOOD     = 0;
	localparam int KIND_BAD_STOP = 1;
	localparam int KIND_GLITCH   = 2;
	localparam logic [7:0] PATTERNS [4] = '{8'h00, 8'hff, 8'h55, 8'haa};

	logic       sys_clk;
	logic       sys_rst_n;
	logic       rx;
	logic       tx;
	err_stat_t  err_stat;
	logic [7:0] sent_data [$];  // logged frames, in send order
	int         sent_kind [$];
	int         sent_cyc [$];
	logic [7:0] exp_q [$];
	logic [7:0] got_q [$];      // decoded from tx
	logic [7:0] burst_q [$];
	err_stat_t  exp_stat;
	int         checked_n = 0;
	int         cyc = 0;
	int         seed;
	int         val_errs = 0;
	int         proto_errs = 0;
	bit         cmp_pending = 1'b0;
	bit         burst_mode = 1'b0;

	tb_clock_gen u_clk (.sys_clk(sys_clk), .sys_rst_n(sys_rst_n));

	uart_echo_top dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (rx),
		.tx        (tx),
		.err_stat  (err_stat)
	);

	always @(posedge sys_clk)
		cyc <= cyc + 1;

	task automatic check_byte(input string name, input logic [7:0] expv, input logic [7:0] actv);
		if (actv !== expv) begin
			$display("[ERROR] %0d ns %s expected 0x%02h got 0x%02h", $time, name, expv, actv);
			val_errs++;
		end
	endtask

	task automatic check_stat(input string name, input err_stat_t expv, input err_stat_t actv);
		if (actv !== expv) begin
			$display("[ERROR] %0d ns %s expected fe=%0d ov=%0d got fe=%0d ov=%0d", $time, name,
				expv.frame_err_cnt, expv.overrun_cnt, actv.frame_err_cnt, actv.overrun_cnt);
			val_errs++;
		end
	endtask

	task automatic check_line(input string name, input logic expv, input logic actv);
		if (actv !== expv) begin
			$display("[ERROR] %0d ns %s expected %b got %b", $time, name, expv, actv);
			val_errs++;
		end
	endtask

	// called at posedge + 1 ns, returns at posedge + 1 ns
	task automatic hold_line(input logic level, input int cycles);
		rx = level;
		repeat (cycles) @(posedge sys_clk);
		#1;
	endtask

	task automatic send_frame(input logic [7:0] data, input int stop_bits, input bit bad_stop);
		hold_line(1'b0, CLKS_PER_BIT);
		for (int i = 0; i < DATA_BITS; i++)
			hold_line(data[i], CLKS_PER_BIT);  // lsb first
		hold_line(~bad_stop, CLKS_PER_BIT);     // the stop bit the receiver checks
		for (int s = 1; s < stop_bits; s++)
			hold_line(1'b1, CLKS_PER_BIT);
	endtask

	task automatic send_glitch();
		hold_line(1'b0, GLITCH_CYC);
		hold_line(1'b1, CLKS_PER_BIT);
	endtask

	task automatic log_frame(input logic [7:0] data, input int kind);
		sent_data.push_back(data);
		sent_kind.push_back(kind);
		sent_cyc.push_back(cyc);
	endtask

	// tx must rest high for QUIET_CYC cycles in a row
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < QUIET_CYC) begin
			@(negedge sys_clk);
			if (tx === 1'b1)
				quiet++;
			else
				quiet = 0;
		end
		@(posedge sys_clk);
		#1;
	endtask

	/*
	 * expected echo stream and status from the logged frames;
	 * the queue model drains one echo frame per TX_SLOT_CYC
	 */
	function automatic err_stat_t ref_model();
		int        pend_cyc [$];  // write cycles of bytes not yet taken by tx
		int        tx_free;
		int        start;
		int        fe;
		int        ov;
		err_stat_t st;
		exp_q.delete();
		tx_free = 0;
		fe = 0;
		ov = 0;
		for (int i = 0; i < sent_data.size(); i++) begin
			while (pend_cyc.size() > 0) begin
				start = (tx_free > pend_cyc[0] + 1) ? tx_free : pend_cyc[0] + 1;
				if (start >= sent_cyc[i])
					break;
				void'(pend_cyc.pop_front());
				tx_free = start + TX_SLOT_CYC;
			end
			case (sent_kind[i])
				KIND_GOOD: begin
					if (pend_cyc.size() < FIFO_DEPTH) begin
						pend_cyc.push_back(sent_cyc[i]);
						exp_q.push_back(sent_data[i]);
					end else if (ov < 255) begin
						ov++;
					end
				end
				KIND_BAD_STOP: begin
					if (fe < 255)
						fe++;
				end
				default: ;  // glitch leaves no trace
			endcase
		end
		st.frame_err_cnt = 8'(fe);
		st.overrun_cnt   = 8'(ov);
		return st;
	endfunction

	task automatic check_echo();
		if (got_q.size() != exp_q.size()) begin
			$display("echo count wrong at %0d ns: expected %0d bytes so far, decoded %0d",
				$time, exp_q.size(), got_q.size());
			proto_errs++;
		end
		for (int i = checked_n; i < exp_q.size() && i < got_q.size(); i++)
			check_byte($sformatf("tx echo byte %0d", i), exp_q[i], got_q[i]);
		checked_n = got_q.size();
		check_stat("err_stat", exp_stat, err_stat);
	endtask

	// burst echoes must be an in-order subset of what was sent
	task automatic check_burst();
		int        j;
		int        n_echo;
		err_stat_t expv;
		j = 0;
		n_echo = got_q.size() - checked_n;
		for (int k = checked_n; k < got_q.size(); k++) begin
			while (j < burst_q.size() && burst_q[j] != got_q[k])
				j++;
			if (j == burst_q.size()) begin
				$display("burst echo 0x%02h at position %0d is out of order or was never sent",
					got_q[k], k - checked_n);
				proto_errs++;
			end else begin
				j++;
			end
		end
		if (n_echo >= BURST_FRAMES) begin
			$display("burst of %0d frames caused no overrun", BURST_FRAMES);
			proto_errs++;
		end
		expv.frame_err_cnt = exp_stat.frame_err_cnt;
		expv.overrun_cnt   = exp_stat.overrun_cnt + 8'(BURST_FRAMES - n_echo);
		check_stat("err_stat", expv, err_stat);
		checked_n = got_q.size();
	endtask

	task automatic request_compare(input bit burst);
		burst_mode  = burst;
		cmp_pending = 1'b1;
		wait (!cmp_pending);
	endtask

	initial begin : compare_proc
		forever begin
			wait (cmp_pending);
			if (burst_mode)
				check_burst();
			else
				check_echo();
			cmp_pending = 1'b0;
		end
	end

	// decodes tx at mid-bit, negedge sampling keeps clear of tx updates
	initial begin : tx_monitor
		logic [7:0] b;
		wait (sys_rst_n === 1'b1);
		forever begin
			@(negedge tx);
			repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
			if (tx !== 1'b0) begin
				$display("echo start bit at %0d ns is not low at mid-bit", $time);
				proto_errs++;
			end
			for (int i = 0; i < DATA_BITS; i++) begin
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				b[i] = tx;
			end
			for (int s = 0; s < TX_STOP_BITS; s++) begin
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				if (tx !== 1'b1) begin
					$display("stop bit %0d of echo 0x%02h at %0d ns is low", s, b, $time);
					proto_errs++;
				end
			end
			got_q.push_back(b);
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired at %0d ns, the echo traffic did not finish", $time);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : main_seq
		logic [7:0] b;
		rx = 1'b1;
		seed = 21;
		wait (sys_rst_n === 1'b1);

		// line idle and counters clear after reset
		for (int i = 0; i < 20; i++) begin
			@(negedge sys_clk);
			check_line("tx", 1'b1, tx);
		end
		check_stat("err_stat", '0, err_stat);
		@(posedge sys_clk);
		#1;

		for (int i = 0; i < RANDOM_FRAMES; i++) begin
			b = 8'($random(seed));
			send_frame(b, 1, 1'b0);
			log_frame(b, KIND_GOOD);
			hold_line(1'b1, GAP_CYC);
		end
		wait_quiet();
		exp_stat = ref_model();
		request_compare(1'b0);

		for (int i = 0; i < 7; i++) begin  // odd positions get a low stop bit
			b = 8'($random(seed));
			send_frame(b, 1, i % 2 == 1);
			log_frame(b, (i % 2 == 1) ? KIND_BAD_STOP : KIND_GOOD);
			hold_line(1'b1, GAP_CYC);
		end
		wait_quiet();
		exp_stat = ref_model();
		request_compare(1'b0);

		send_glitch();
		log_frame(8'h00, KIND_GLITCH);
		hold_line(1'b1, GAP_CYC);
		wait_quiet();
		exp_stat = ref_model();
		request_compare(1'b0);

		for (int i = 0; i < 4; i++) begin
			send_frame(PATTERNS[i], 2, 1'b0);
			log_frame(PATTERNS[i], KIND_GOOD);
			hold_line(1'b1, GAP_CYC);
		end
		wait_quiet();
		exp_stat = ref_model();
		request_compare(1'b0);

		// back to back, input frames are shorter than echo frames
		for (int i = 0; i < BURST_FRAMES; i++) begin
			b = 8'($random(seed));
			burst_q.push_back(b);
			send_frame(b, 1, 1'b0);
		end
		wait_quiet();
		request_compare(1'b1);

		$display("checks done: %0d value errors, %0d other failures", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- flist.f
rtl/uart_cfg_pkg.sv
rtl/uart_types_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/byte_fifo.sv
rtl/uart_echo_top.sv
test/tb_clock_gen.sv
test/tb_uart_echo.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the UART echo testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_uart_echo \
	-f flist.f \
	-o sim_uart_echo

out="$(./obj_dir/sim_uart_echo)"
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1
